// File: Makefile
# Verilator build and run for the AXI-Stream packetizer

LOG = sim.log

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f axis_pkt_top.f \
		--top-module axis_pkt_tb -o sim_axis_pkt

run: build
	./obj_dir/sim_axis_pkt | tee $(LOG)
	grep -q "All tests passed" $(LOG)

lint:
	verilator --lint-only -Wall -f axis_pkt_top.f --top-module axis_pkt_top

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all build run lint clean

// File: axis_if.sv
// ====================
// AXI-Stream link between converter and merger
// ====================

`default_nettype none

interface axis_if;
   import axis_pkt_pkg::*;

   logic  tvalid;
   logic  tready;
   data_t tdata;
   logic  tlast;

   modport src (
      output tvalid,
      output tdata,
      output tlast,
      input  tready
   );

   modport snk (
      input  tvalid,
      input  tdata,
      input  tlast,
      output tready
   );

endinterface

`default_nettype wire

// File: axis_pkt_consts.svh
// ====================
// packetizer widths and FIFO depth
// ====================

`ifndef AXIS_PKT_CONSTS_SVH
`define AXIS_PKT_CONSTS_SVH

// stream word width
`define AXIS_DATA_W 16

// packet length and word counter width
`define AXIS_LEN_W 8

// log2 of the FIFO depth
`define FIFO_ADDR_W 4
`define FIFO_DEPTH (1 << `FIFO_ADDR_W)

`endif

// File: axis_pkt_merge.sv
// ====================
// round-robin merger of two packet streams
// ====================

`default_nettype none

module axis_pkt_merge (
   input  wire logic           clk_i,
   input  wire logic           rst_n_i,
   axis_if.snk                 s0,
   axis_if.snk                 s1,
   output logic                m_tvalid_o,
   input  wire logic           m_tready_i,
   output axis_pkt_pkg::data_t m_tdata_o,
   output logic                m_tlast_o,
   output logic                m_tid_o
);
   import axis_pkt_pkg::*;

   merge_state_e state;
   merge_state_e state_nxt;
   logic         last_grant;
   logic         gnt_act;
   logic         gnt_id;
   logic         beat_last;

   // grant source, idle picks combinationally
   always_comb begin
      gnt_act = 1'b1;
      gnt_id  = last_grant;
      case (state)
         MERGE_CH0: gnt_id = 1'b0;
         MERGE_CH1: gnt_id = 1'b1;
         default: begin
            if (s0.tvalid && s1.tvalid) begin
               // both waiting, serve the other one
               gnt_id = ~last_grant;
            end else if (s0.tvalid) begin
               gnt_id = 1'b0;
            end else if (s1.tvalid) begin
               gnt_id = 1'b1;
            end else begin
               gnt_act = 1'b0;
            end
         end
      endcase
   end

   assign m_tvalid_o = gnt_act & (gnt_id ? s1.tvalid : s0.tvalid);
   assign m_tdata_o  = gnt_id ? s1.tdata : s0.tdata;
   assign m_tlast_o  = gnt_id ? s1.tlast : s0.tlast;
   assign m_tid_o    = gnt_id;

   assign s0.tready = gnt_act & ~gnt_id & m_tready_i;
   assign s1.tready = gnt_act & gnt_id & m_tready_i;

   assign beat_last = m_tvalid_o & m_tready_i & m_tlast_o;

   always_comb begin
      state_nxt = state;
      if (beat_last) begin
         state_nxt = MERGE_IDLE;
      end else if (state == MERGE_IDLE && gnt_act) begin
         // lock the channel until its packet ends
         state_nxt = gnt_id ? MERGE_CH1 : MERGE_CH0;
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state      <= MERGE_IDLE;
         last_grant <= 1'b1;
      end else begin
         state <= state_nxt;
         if (state == MERGE_IDLE && gnt_act) begin
            last_grant <= gnt_id;
         end
      end
   end

   // packets never interleave on the master side
   a_grant_hold: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      m_tvalid_o && !beat_last |=> state != MERGE_IDLE && m_tid_o == $past(m_tid_o)
   ) else $error("axis_pkt_merge: grant moved inside a packet");

   a_no_ready_ch0: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      state == MERGE_CH0 |-> !s1.tready
   ) else $error("axis_pkt_merge: ch1 saw tready while ch0 granted");

   a_no_ready_ch1: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      state == MERGE_CH1 |-> !s0.tready
   ) else $error("axis_pkt_merge: ch0 saw tready while ch1 granted");

endmodule

`default_nettype wire

// File: axis_pkt_pkg.sv
// ====================
// shared packetizer types
// ====================

`default_nettype none

`include "axis_pkt_consts.svh"

package axis_pkt_pkg;

   typedef logic [`AXIS_DATA_W-1:0] data_t;

   // packet length in words, 1 to 255
   typedef logic [`AXIS_LEN_W-1:0] len_t;

   typedef enum logic [1:0] {
      MERGE_IDLE = 2'd0,
      MERGE_CH0  = 2'd1,
      MERGE_CH1  = 2'd2
   } merge_state_e;

endpackage

`default_nettype wire

// File: axis_pkt_tb.sv
// ====================
// packetizer testbench, random traffic
// checked against queue model
// ====================

`default_nettype none

module axis_pkt_tb;
   import axis_pkt_pkg::*;

   localparam int timeout_cycles = 2000;

   logic  clk;
   logic  rst_n;
   logic  en;
   logic  ch0_wr_en;
   data_t ch0_wr_data;
   len_t  ch0_len;
   logic  ch0_full;
   logic  ch1_wr_en;
   data_t ch1_wr_data;
   len_t  ch1_len;
   logic  ch1_full;
   logic  m_tvalid;
   logic  m_tready;
   data_t m_tdata;
   logic  m_tlast;
   logic  m_tid;

   // model state
   data_t q0[$];
   data_t q1[$];
   bit    pkt_tids[$];
   int    beat_cnt[2];
   int    beat_total[2];
   bit    stall_prev;
   data_t hold_data;
   logic  hold_last;
   logic  hold_tid;
   bit    mid_pkt;
   logic  pkt_tid;
   bit    bp_on;
   int    errors;
   int    timeouts;
   int    tests_run;
   int    tests_failed;
   int    test_start;

   axis_pkt_top UUT (
      .clk_i(clk), .rst_n_i(rst_n), .en_i(en),
      .ch0_wr_en_i(ch0_wr_en), .ch0_wr_data_i(ch0_wr_data),
      .ch0_len_i(ch0_len), .ch0_full_o(ch0_full),
      .ch1_wr_en_i(ch1_wr_en), .ch1_wr_data_i(ch1_wr_data),
      .ch1_len_i(ch1_len), .ch1_full_o(ch1_full),
      .m_tvalid_o(m_tvalid), .m_tready_i(m_tready), .m_tdata_o(m_tdata),
      .m_tlast_o(m_tlast), .m_tid_o(m_tid)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // ready is either held high or toggled at random
   initial begin
      m_tready = 1'b1;
      forever begin
         @(posedge clk);
         #1;
         m_tready = bp_on ? (($urandom % 2) == 0) : 1'b1;
      end
   end

   function automatic int len_of(input int ch);
      return (ch == 1) ? int'(ch1_len) : int'(ch0_len);
   endfunction

   // one transferred beat against the head of its channel queue
   task automatic check_beat();
      int    ch;
      data_t exp_data;
      logic  exp_last;
      ch = m_tid ? 1 : 0;
      if ((ch == 0 && q0.size() == 0) || (ch == 1 && q1.size() == 0)) begin
         errors++;
         $display("Error at %0t: unexpected beat on ch%0d, data %h", $time, ch, m_tdata);
      end else begin
         if (ch == 1) begin
            exp_data = q1.pop_front();
         end else begin
            exp_data = q0.pop_front();
         end
         exp_last = (beat_cnt[ch] + 1 == len_of(ch));
         if (m_tdata !== exp_data) begin
            errors++;
            $display("Error at %0t: ch%0d data %h, expected %h", $time, ch, m_tdata, exp_data);
         end
         if (m_tlast !== exp_last) begin
            errors++;
            $display("Error at %0t: ch%0d tlast %b, expected %b", $time, ch, m_tlast, exp_last);
         end
         beat_cnt[ch] = exp_last ? 0 : beat_cnt[ch] + 1;
         beat_total[ch]++;
      end
      if (m_tlast) begin
         pkt_tids.push_back(m_tid);
      end
      mid_pkt = !m_tlast;
      pkt_tid = m_tid;
   endtask

   // monitor samples mid-cycle where values hold until the next rising edge
   always @(negedge clk) begin
      if (rst_n) begin
         if (ch0_wr_en && !ch0_full) begin
            q0.push_back(ch0_wr_data);
         end
         if (ch1_wr_en && !ch1_full) begin
            q1.push_back(ch1_wr_data);
         end
         if (stall_prev && (!m_tvalid || m_tdata !== hold_data ||
                            m_tlast !== hold_last || m_tid !== hold_tid)) begin
            errors++;
            $display("Error at %0t: master beat changed while stalled", $time);
         end
         if (m_tvalid && mid_pkt && m_tid !== pkt_tid) begin
            errors++;
            $display("Error at %0t: tid %b inside a ch%0d packet", $time, m_tid, pkt_tid);
         end
         if (m_tvalid && m_tready) begin
            check_beat();
         end
         stall_prev = m_tvalid && !m_tready;
         hold_data  = m_tdata;
         hold_last  = m_tlast;
         hold_tid   = m_tid;
      end
   end

   // sparse writes skip about half the cycles
   task automatic write_words(input int n0, input int n1, input bit sparse);
      int done0;
      int done1;
      int cycles;
      done0  = 0;
      done1  = 0;
      cycles = 0;
      while ((done0 < n0 || done1 < n1) && cycles < timeout_cycles) begin
         @(posedge clk);
         #1;
         ch0_wr_en = 1'b0;
         ch1_wr_en = 1'b0;
         if (done0 < n0 && !ch0_full && (!sparse || ($urandom % 2) == 0)) begin
            ch0_wr_en   = 1'b1;
            ch0_wr_data = data_t'($urandom);
            done0++;
         end
         if (done1 < n1 && !ch1_full && (!sparse || ($urandom % 2) == 0)) begin
            ch1_wr_en   = 1'b1;
            ch1_wr_data = data_t'($urandom);
            done1++;
         end
         cycles++;
      end
      @(posedge clk);
      #1;
      ch0_wr_en = 1'b0;
      ch1_wr_en = 1'b0;
      if (done0 < n0 || done1 < n1) begin
         timeouts++;
         $display("Timeout: FIFO stayed full, writes could not finish");
      end
   endtask

   task automatic wait_drain();
      int cycles;
      cycles = 0;
      while ((q0.size() != 0 || q1.size() != 0 || m_tvalid) && cycles < timeout_cycles) begin
         @(posedge clk);
         #1;
         cycles++;
      end
      if (q0.size() != 0 || q1.size() != 0 || m_tvalid) begin
         timeouts++;
         $display("Timeout: expected words never came out of the master stream");
      end
   endtask

   task automatic finish_test(input string name);
      tests_run++;
      if (errors + timeouts > test_start) begin
         tests_failed++;
         $display("test %0d %s: failed", tests_run, name);
      end else begin
         $display("test %0d %s: passed", tests_run, name);
      end
      test_start = errors + timeouts;
   endtask

   initial begin
      int npk;
      int start_total;
      int cycles;
      void'($urandom(47861));
      rst_n       = 1'b0;
      en          = 1'b0;
      ch0_wr_en   = 1'b0;
      ch0_wr_data = '0;
      ch1_wr_en   = 1'b0;
      ch1_wr_data = '0;
      // lengths stay fixed for the whole run
      ch0_len     = len_t'(4);
      ch1_len     = len_t'(1 + $urandom % 8);
      // ch1 never shares the ch0 length
      if (ch1_len == len_t'(4)) begin
         ch1_len = len_t'(7);
      end
      repeat (5) @(posedge clk);
      #1;
      rst_n = 1'b1;

      if (m_tvalid !== 1'b0 || ch0_full !== 1'b0 || ch1_full !== 1'b0) begin
         errors++;
         $display("Error at %0t: outputs not idle after reset", $time);
      end
      en = 1'b1;
      start_total = beat_total[0];
      write_words(20, 0, 1'b0);
      wait_drain();
      if (beat_total[0] - start_total != 20) begin
         errors++;
         $display("Error at %0t: ch0 sent %0d beats, expected 20", $time,
                  beat_total[0] - start_total);
      end
      finish_test("reset and single channel");

      bp_on = 1'b1;
      write_words(0, 5 * int'(ch1_len), 1'b0);
      wait_drain();
      finish_test("back-pressure");

      write_words(6 * int'(ch0_len), 4 * int'(ch1_len), 1'b1);
      wait_drain();
      finish_test("mixed traffic");

      // preload with the converters stopped and then release both
      bp_on = 1'b0;
      en    = 1'b0;
      npk   = 16 / int'(ch1_len);
      if (npk > 4) begin
         npk = 4;
      end
      write_words(npk * int'(ch0_len), npk * int'(ch1_len), 1'b0);
      pkt_tids.delete();
      en = 1'b1;
      wait_drain();
      if (pkt_tids.size() != 2 * npk) begin
         errors++;
         $display("Error at %0t: %0d packets, expected %0d", $time, pkt_tids.size(), 2 * npk);
      end
      for (int i = 1; i < pkt_tids.size(); i++) begin
         if (pkt_tids[i] == pkt_tids[i-1]) begin
            errors++;
            $display("Error at %0t: packet %0d repeats channel %0d", $time, i, pkt_tids[i]);
         end
      end
      finish_test("fairness");

      en = 1'b0;
      write_words(16, 0, 1'b0);
      cycles = 0;
      while (!ch0_full && cycles < timeout_cycles) begin
         @(posedge clk);
         #1;
         cycles++;
      end
      if (!ch0_full) begin
         timeouts++;
         $display("Timeout: ch0 full flag never went high");
      end
      // this word must be dropped
      ch0_wr_en   = 1'b1;
      ch0_wr_data = data_t'($urandom);
      @(posedge clk);
      #1;
      ch0_wr_en = 1'b0;
      repeat (30) begin
         if (m_tvalid) begin
            errors++;
            $display("Error at %0t: m_tvalid_o high while disabled", $time);
         end
         @(posedge clk);
         #1;
      end
      start_total = beat_total[0];
      en = 1'b1;
      wait_drain();
      if (beat_total[0] - start_total != 16) begin
         errors++;
         $display("Error at %0t: ch0 sent %0d beats, expected 16", $time,
                  beat_total[0] - start_total);
      end
      finish_test("enable and full");

      $display("tests run %0d, failed %0d, errors %0d, timeouts %0d",
               tests_run, tests_failed, errors, timeouts);
      if (tests_failed == 0 && errors == 0 && timeouts == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: axis_pkt_top.f
+incdir+.
axis_pkt_pkg.sv
axis_if.sv
sync_fifo.sv
fifo2axis.sv
axis_pkt_merge.sv
axis_pkt_top.sv
axis_pkt_tb.sv

// File: axis_pkt_top.sv
// ====================
// two-channel AXI-Stream packetizer
// ====================

`default_nettype none

module axis_pkt_top (
   input  wire logic                clk_i,
   input  wire logic                rst_n_i,
   input  wire logic                en_i,
   input  wire logic                ch0_wr_en_i,
   input  wire axis_pkt_pkg::data_t ch0_wr_data_i,
   input  wire axis_pkt_pkg::len_t  ch0_len_i,
   output logic                     ch0_full_o,
   input  wire logic                ch1_wr_en_i,
   input  wire axis_pkt_pkg::data_t ch1_wr_data_i,
   input  wire axis_pkt_pkg::len_t  ch1_len_i,
   output logic                     ch1_full_o,
   output logic                     m_tvalid_o,
   input  wire logic                m_tready_i,
   output axis_pkt_pkg::data_t      m_tdata_o,
   output logic                     m_tlast_o,
   output logic                     m_tid_o
);
   import axis_pkt_pkg::*;

   logic  fifo0_read;
   logic  fifo0_empty;
   data_t fifo0_rdata;
   logic  fifo1_read;
   logic  fifo1_empty;
   data_t fifo1_rdata;

   axis_if s0_axis ();
   axis_if s1_axis ();

   // channel 0
   sync_fifo u_fifo0 (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .wr_en_i  (ch0_wr_en_i),
      .wr_data_i(ch0_wr_data_i),
      .full_o   (ch0_full_o),
      .rd_en_i  (fifo0_read),
      .rd_data_o(fifo0_rdata),
      .empty_o  (fifo0_empty)
   );

   fifo2axis u_conv0 (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .en_i        (en_i),
      .len_i       (ch0_len_i),
      .fifo_read_o (fifo0_read),
      .fifo_empty_i(fifo0_empty),
      .fifo_rdata_i(fifo0_rdata),
      .m_axis      (s0_axis.src),
      .level_o     ()
   );

   // channel 1
   sync_fifo u_fifo1 (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .wr_en_i  (ch1_wr_en_i),
      .wr_data_i(ch1_wr_data_i),
      .full_o   (ch1_full_o),
      .rd_en_i  (fifo1_read),
      .rd_data_o(fifo1_rdata),
      .empty_o  (fifo1_empty)
   );

   fifo2axis u_conv1 (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .en_i        (en_i),
      .len_i       (ch1_len_i),
      .fifo_read_o (fifo1_read),
      .fifo_empty_i(fifo1_empty),
      .fifo_rdata_i(fifo1_rdata),
      .m_axis      (s1_axis.src),
      .level_o     ()
   );

   axis_pkt_merge u_merge (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .s0        (s0_axis.snk),
      .s1        (s1_axis.snk),
      .m_tvalid_o(m_tvalid_o),
      .m_tready_i(m_tready_i),
      .m_tdata_o (m_tdata_o),
      .m_tlast_o (m_tlast_o),
      .m_tid_o   (m_tid_o)
   );

endmodule

`default_nettype wire

// File: fifo2axis.sv
// ====================
// FIFO to AXI-Stream converter
// cuts the word flow into packets of len_i words
// ====================

`default_nettype none

module fifo2axis (
   input  wire logic               clk_i,
   input  wire logic               rst_n_i,
   input  wire logic               en_i,
   input  wire axis_pkt_pkg::len_t len_i,
   output logic                    fifo_read_o,
   input  wire logic               fifo_empty_i,
   input  wire axis_pkt_pkg::data_t fifo_rdata_i,
   axis_if.src                     m_axis,
   output logic [1:0]              level_o
);
   import axis_pkt_pkg::*;

   logic  fifo_read_r;
   logic  read_cond;
   logic  output_en;
   logic  saved;
   data_t saved_tdata;
   logic  saved_tlast;
   len_t  word_cnt;
   len_t  len_m1;
   logic  tlast_nxt;

   // read when the output moves or when nothing is held or in flight
   assign read_cond   = m_axis.tready | ~(saved | fifo_read_r);
   assign fifo_read_o = en_i & ~fifo_empty_i & read_cond;

   assign output_en = ~m_axis.tvalid | m_axis.tready;

   // counter already points at the word now arriving
   assign len_m1    = len_i - 1'b1;
   assign tlast_nxt = (word_cnt == len_m1);

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         fifo_read_r <= 1'b0;
         saved       <= 1'b0;
         // all ones so the first read lands on zero
         word_cnt    <= '1;
      end else begin
         fifo_read_r <= fifo_read_o;
         if (output_en) begin
            saved <= 1'b0;
         end else if (fifo_read_r) begin
            saved <= 1'b1;
         end
         if (fifo_read_o) begin
            word_cnt <= (word_cnt == len_m1) ? '0 : word_cnt + 1'b1;
         end
      end
   end

   // holding slot
   always_ff @(posedge clk_i) begin
      if (fifo_read_r) begin
         saved_tdata <= fifo_rdata_i;
         saved_tlast <= tlast_nxt;
      end
   end

   // output register loads the slot first
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         m_axis.tvalid <= 1'b0;
         m_axis.tlast  <= 1'b0;
      end else if (output_en) begin
         m_axis.tvalid <= saved | fifo_read_r;
         m_axis.tlast  <= saved ? saved_tlast : tlast_nxt;
      end
   end

   always_ff @(posedge clk_i) begin
      if (output_en) begin
         m_axis.tdata <= saved ? saved_tdata : fifo_rdata_i;
      end
   end

   always_comb begin
      if (saved && m_axis.tvalid) begin
         level_o = 2'd2;
      end else if (saved || m_axis.tvalid) begin
         level_o = 2'd1;
      end else begin
         level_o = 2'd0;
      end
   end

   // a word in flight must never meet an occupied slot
   a_no_overrun: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      saved |-> !fifo_read_r
   ) else $error("fifo2axis: word arrived while the slot was full");

   a_slot_behind_out: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      saved |-> m_axis.tvalid
   ) else $error("fifo2axis: slot holds a word behind an empty output");

   // stream rule across stalled cycles
   a_tvalid_hold: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      m_axis.tvalid && !m_axis.tready |=>
         m_axis.tvalid && $stable(m_axis.tdata) && $stable(m_axis.tlast)
   ) else $error("fifo2axis: output changed while stalled");

endmodule

`default_nettype wire

// File: sync_fifo.sv
// ====================
// synchronous FIFO, registered read data
// ====================

`default_nettype none

`include "axis_pkt_consts.svh"

module sync_fifo (
   input  wire logic                clk_i,
   input  wire logic                rst_n_i,
   input  wire logic                wr_en_i,
   input  wire axis_pkt_pkg::data_t wr_data_i,
   output logic                     full_o,
   input  wire logic                rd_en_i,
   output axis_pkt_pkg::data_t      rd_data_o,
   output logic                     empty_o
);
   import axis_pkt_pkg::*;

   localparam int unsigned ADDR_W = `FIFO_ADDR_W;
   localparam int unsigned DEPTH  = `FIFO_DEPTH;

   data_t             mem [DEPTH];
   // pointers carry one extra bit to tell full from empty
   logic [ADDR_W:0]   wr_ptr;
   logic [ADDR_W:0]   rd_ptr;
   logic [ADDR_W:0]   fill;
   logic              wr_ok;
   logic              rd_ok;

   assign empty_o = (wr_ptr == rd_ptr);
   assign full_o  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                    (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

   // words stored, wraps with the pointers
   assign fill = wr_ptr - rd_ptr;

   // blocked accesses are dropped
   assign wr_ok = wr_en_i & ~full_o;
   assign rd_ok = rd_en_i & ~empty_o;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (wr_ok) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_ok) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   // storage and read port
   always_ff @(posedge clk_i) begin
      if (wr_ok) begin
         mem[wr_ptr[ADDR_W-1:0]] <= wr_data_i;
      end
      if (rd_ok) begin
         rd_data_o <= mem[rd_ptr[ADDR_W-1:0]];
      end
   end

   // the reader must watch empty_o itself
   a_no_read_empty: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      rd_en_i |-> !empty_o
   ) else $error("sync_fifo: read strobe while empty");

   a_fill_max: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      fill <= DEPTH
   ) else $error("sync_fifo: more words stored than entries");

endmodule

`default_nettype wire
